// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = scope_overlay_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: list.f
+incdir+.
scope_pkg.sv
scope_key_sync.sv
scope_column_pacer.sv
scope_plot_rules.sv
scope_pixel_out.sv
scope_overlay_top.sv
scope_overlay_tb.sv

// File: scope_column_pacer.sv
`timescale 1ns/1ps
`default_nettype none

`include "scope_settings.svh"

module scope_column_pacer
    import scope_pkg::*;
(
    input  wire     pix_clk,
    input  wire     rstn,
    input  logic    i_de,
    output pace_t   o_phase,
    output logic    o_point_done
);

    localparam pace_t PACE_END = pace_t'(`SCOPE_PACE_LAST);

    pace_t  phase_q;
    pace_t  phase_d;

    // last step always wraps, even outside the active area
    always_comb
    begin
        if (phase_q == PACE_END)
            phase_d = PACE_GAP;
        else if (i_de)
            phase_d = pace_t'(phase_q + 3'd1);
        else
            phase_d = phase_q;
    end

    always_ff @(posedge pix_clk or negedge rstn)
    begin
        if (!rstn)
            phase_q <= PACE_GAP;
        else
            phase_q <= phase_d;
    end

    assign o_phase      = phase_q;

    // sample source advances once per five active columns
    assign o_point_done = (phase_q == PACE_END);

    a_phase_range: assert property (@(posedge pix_clk) disable iff (!rstn)
        phase_q <= PACE_BAR_B);

    a_phase_wrap: assert property (@(posedge pix_clk) disable iff (!rstn)
        (phase_q == PACE_BAR_B) |=> (phase_q == PACE_GAP));

endmodule

`default_nettype wire

// File: scope_key_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "scope_settings.svh"

module scope_key_sync
    import scope_pkg::*;
(
    input  wire                         pix_clk,
    input  wire                         rstn,
    input  logic [`SCOPE_KEY_W-1:0]     i_key,
    output view_t                       o_view
);

    localparam logic [`SCOPE_KEY_W-1:0] KEY_TRACE    = `SCOPE_KEY_W'(0);
    localparam logic [`SCOPE_KEY_W-1:0] KEY_SPECTRUM = `SCOPE_KEY_W'(1);

    logic [`SCOPE_KEY_W-1:0]    key_meta;
    logic [`SCOPE_KEY_W-1:0]    key_sync;

    // key comes from switches, asynchronous to pix_clk
    always_ff @(posedge pix_clk or negedge rstn)
    begin
        if (!rstn)
        begin
            key_meta <= KEY_TRACE;
            key_sync <= KEY_TRACE;
        end
        else
        begin
            key_meta <= i_key;
            key_sync <= key_meta;
        end
    end

    always_comb
    begin
        case (key_sync)
            KEY_TRACE:    o_view = VIEW_TRACE;
            KEY_SPECTRUM: o_view = VIEW_SPECTRUM;
            default:      o_view = VIEW_BLANK;
        endcase
    end

    a_view_legal: assert property (@(posedge pix_clk) disable iff (!rstn)
        o_view inside {VIEW_TRACE, VIEW_SPECTRUM, VIEW_BLANK});

endmodule

`default_nettype wire

// File: scope_overlay_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "scope_settings.svh"

module scope_overlay_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 8;
    localparam int PACER_CYCLES = 300;
    localparam int TRACE_CYCLES = 1500;
    localparam int SPECT_CYCLES = 1500;
    localparam int MIXED_CYCLES = 800;
    localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + PACER_CYCLES
                                + TRACE_CYCLES + SPECT_CYCLES + MIXED_CYCLES + 16;

    // view and phase codes of the reference model
    localparam int SHOW_TRACE    = 0;
    localparam int SHOW_SPECTRUM = 1;
    localparam int SHOW_BLANK    = 2;
    localparam int PH_DASH_A     = 1;
    localparam int PH_DASH_B     = 2;
    localparam int PH_BAR_A      = 3;
    localparam int PH_BAR_B      = 4;

    logic                           pix_clk;
    logic                           rstn;
    logic [`SCOPE_COORD_W-1:0]      act_x;
    logic [`SCOPE_COORD_W-1:0]      act_y;
    logic                           vs;
    logic                           hs;
    logic                           de;
    logic [`SCOPE_KEY_W-1:0]        key;
    logic [`SCOPE_SAMPLE_W-1:0]     dram_data;
    logic                           out_vs;
    logic                           out_hs;
    logic                           out_de;
    logic [7:0]                     out_r;
    logic [7:0]                     out_g;
    logic [7:0]                     out_b;
    logic                           point_done;

    int                             seed;
    int                             checks = 0;
    int                             errors = 0;

    // reference model state
    logic [`SCOPE_KEY_W-1:0]        key_meta_m = '0;
    logic [`SCOPE_KEY_W-1:0]        key_sync_m = '0;
    int                             phase_m    = 0;
    logic [`SCOPE_COLOR_W-1:0]      exp_color  = `SCOPE_PAPER;
    logic                           exp_vs     = 1'b0;
    logic                           exp_hs     = 1'b0;
    logic                           exp_de     = 1'b0;
    logic                           exp_pd     = 1'b0;
    logic                           prev_pd    = 1'b0;
    logic                           armed      = 1'b0;

    scope_overlay_top scope_overlay_top_inst
    (
        .pix_clk        (pix_clk),
        .rstn           (rstn),
        .i_act_x        (act_x),
        .i_act_y        (act_y),
        .i_vs           (vs),
        .i_hs           (hs),
        .i_de           (de),
        .i_key          (key),
        .i_dram_data    (dram_data),
        .o_vs           (out_vs),
        .o_hs           (out_hs),
        .o_de           (out_de),
        .o_r            (out_r),
        .o_g            (out_g),
        .o_b            (out_b),
        .o_point_done   (point_done)
    );

    initial
    begin
        pix_clk = 1'b0;
        forever #(CLK_PERIOD / 2) pix_clk = ~pix_clk;
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic int view_of_key(input logic [`SCOPE_KEY_W-1:0] k);
        case (k)
            `SCOPE_KEY_W'(0): return SHOW_TRACE;
            `SCOPE_KEY_W'(1): return SHOW_SPECTRUM;
            default:          return SHOW_BLANK;
        endcase
    endfunction

    // expected colour of one pixel
    function automatic logic [`SCOPE_COLOR_W-1:0] ref_color(input int view, input int phase,
                                                            input int x, input int y,
                                                            input logic [`SCOPE_SAMPLE_W-1:0] data);
        int tv;
        int fv;
        bit bar;
        bit dash;
        bit wide;
        bit upper;
        bit dark;
        tv    = 32'(data[7:0]);
        fv    = 32'(data[9:1]);
        bar   = (phase == PH_BAR_A) || (phase == PH_BAR_B);
        dash  = (phase == PH_DASH_A) || (phase == PH_DASH_B);
        wide  = (x >= `SCOPE_LABEL_COLS);
        upper = (y < `SCOPE_MID_ROW) && bar && (y + fv > `SCOPE_MID_ROW + 1);
        dark  = 1'b0;
        if (view == SHOW_TRACE)
            dark = upper || (y == `SCOPE_MID_ROW)
                || (wide && (y >= `SCOPE_TRACE_TOP) && (y <= `SCOPE_TRACE_BASE)
                    && ((tv == `SCOPE_TRACE_BASE - y) || (tv == `SCOPE_TRACE_BASE - 1 - y)))
                || (wide && dash && ((y == `SCOPE_TRACE_TOP) || (y == `SCOPE_DASH_MID)
                    || (y == `SCOPE_TRACE_BASE)));
        else if (view == SHOW_SPECTRUM)
            dark = upper || (y == `SCOPE_MID_ROW)
                || ((y > `SCOPE_MID_ROW) && (y < `SCOPE_BOTTOM_ROW) && bar
                    && (y + fv > `SCOPE_BOTTOM_ROW))
                || (y == `SCOPE_BOTTOM_ROW);
        return dark ? `SCOPE_INK : `SCOPE_PAPER;
    endfunction

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("[ERROR] %s expected %0h got %0h at %0t", name, expected, actual, $time);
        end
    endtask

    // prediction from the inputs sampled at this edge
    always @(posedge pix_clk)
    begin
        if (!rstn)
        begin
            key_meta_m = '0;
            key_sync_m = '0;
            phase_m    = 0;
            exp_color  = `SCOPE_PAPER;
            exp_vs     = 1'b0;
            exp_hs     = 1'b0;
            exp_de     = 1'b0;
        end
        else
        begin
            exp_color  = ref_color(view_of_key(key_sync_m), phase_m,
                                   32'(act_x), 32'(act_y), dram_data);
            exp_vs     = vs;
            exp_hs     = hs;
            exp_de     = de;
            key_sync_m = key_meta_m;
            key_meta_m = key;
            if (phase_m == `SCOPE_PACE_LAST)
                phase_m = 0;
            else if (de)
                phase_m = phase_m + 1;
        end
        exp_pd = (phase_m == `SCOPE_PACE_LAST);
        armed  = 1'b1;
    end

    // outputs are settled by the falling edge
    always @(negedge pix_clk)
    begin
        if (armed)
        begin
            check_val("{o_r,o_g,o_b}", 32'(exp_color), 32'({out_r, out_g, out_b}));
            check_val("o_vs", 32'(exp_vs), 32'(out_vs));
            check_val("o_hs", 32'(exp_hs), 32'(out_hs));
            check_val("o_de", 32'(exp_de), 32'(out_de));
            check_val("o_point_done", 32'(exp_pd), 32'(point_done));
            check_val("o_point_done repeated", 32'(1'b0), 32'(prev_pd & point_done));
            prev_pd = point_done;
        end
    end

    task automatic drive_syncs();
        vs = (rand_below(2) == 1);
        hs = (rand_below(2) == 1);
        de = (rand_below(4) != 0);
    endtask

    task automatic any_pixel();
        act_x     = `SCOPE_COORD_W'(rand_below(1280));
        act_y     = `SCOPE_COORD_W'((rand_below(4) == 0) ? `SCOPE_MID_ROW : rand_below(750));
        dram_data = `SCOPE_SAMPLE_W'(rand_below(65536));
    endtask

    task automatic trace_pixel();
        int mode;
        int y;
        mode      = rand_below(6);
        y         = 350 + rand_below(371);
        act_x     = `SCOPE_COORD_W'(rand_below(101));
        dram_data = `SCOPE_SAMPLE_W'(rand_below(65536));
        case (mode)
            0, 3:
            begin
                // land on one of the two trace rows
                y = `SCOPE_TRACE_TOP + 1 + rand_below(255);
                dram_data[7:0] = 8'(`SCOPE_TRACE_BASE - y - rand_below(2));
                if (mode == 3)
                    act_x = `SCOPE_COORD_W'(rand_below(`SCOPE_LABEL_COLS));
            end
            1:
            begin
                case (rand_below(3))
                    0:       y = `SCOPE_TRACE_TOP;
                    1:       y = `SCOPE_DASH_MID;
                    default: y = `SCOPE_TRACE_BASE;
                endcase
            end
            2:       y = `SCOPE_MID_ROW;
            default: ;
        endcase
        act_y = `SCOPE_COORD_W'(y);
    endtask

    task automatic spectrum_pixel();
        int y;
        case (rand_below(5))
            0:       y = `SCOPE_MID_ROW;
            1:       y = `SCOPE_BOTTOM_ROW;
            default: y = rand_below(`SCOPE_BOTTOM_ROW + 1);
        endcase
        act_x     = `SCOPE_COORD_W'(rand_below(1280));
        act_y     = `SCOPE_COORD_W'(y);
        dram_data = `SCOPE_SAMPLE_W'(rand_below(65536));
    endtask

    initial
    begin
        int i;
        seed      = 32'h8e67_bb75;
        rstn      = 1'b0;
        act_x     = '0;
        act_y     = '0;
        vs        = 1'b0;
        hs        = 1'b0;
        de        = 1'b0;
        key       = '0;
        dram_data = '0;
        repeat (RESET_CYCLES) @(negedge pix_clk);
        rstn = 1'b1;
        // de low, top-left corner stays paper
        repeat (IDLE_CYCLES) @(negedge pix_clk);
        for (i = 0; i < PACER_CYCLES; i++)
        begin
            @(negedge pix_clk);
            drive_syncs();
            any_pixel();
        end
        for (i = 0; i < TRACE_CYCLES; i++)
        begin
            @(negedge pix_clk);
            drive_syncs();
            trace_pixel();
        end
        key = `SCOPE_KEY_W'(1);
        for (i = 0; i < SPECT_CYCLES; i++)
        begin
            @(negedge pix_clk);
            drive_syncs();
            spectrum_pixel();
        end
        // key hops over all eight codes
        for (i = 0; i < MIXED_CYCLES; i++)
        begin
            @(negedge pix_clk);
            drive_syncs();
            any_pixel();
            if (rand_below(16) == 0)
                key = `SCOPE_KEY_W'(rand_below(8));
        end
        repeat (3) @(negedge pix_clk);
        @(posedge pix_clk);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        #(TOTAL_CYCLES * CLK_PERIOD + 2000);
        $display("timeout: stimulus did not finish within %0d clock cycles", TOTAL_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: scope_overlay_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "scope_settings.svh"

module scope_overlay_top
(
    input  wire                         pix_clk,
    input  wire                         rstn,
    input  logic [`SCOPE_COORD_W-1:0]   i_act_x,
    input  logic [`SCOPE_COORD_W-1:0]   i_act_y,
    input  logic                        i_vs,
    input  logic                        i_hs,
    input  logic                        i_de,
    input  logic [`SCOPE_KEY_W-1:0]     i_key,
    input  logic [`SCOPE_SAMPLE_W-1:0]  i_dram_data,
    output logic                        o_vs,
    output logic                        o_hs,
    output logic                        o_de,
    output logic [7:0]                  o_r,
    output logic [7:0]                  o_g,
    output logic [7:0]                  o_b,
    output logic                        o_point_done
);

    scope_pkg::view_t   view;
    scope_pkg::pace_t   phase;
    scope_pkg::ink_t    ink;

    // view select, two edges behind the key
    scope_key_sync scope_key_sync_inst
    (
        .pix_clk        (pix_clk),
        .rstn           (rstn),
        .i_key          (i_key),
        .o_view         (view)
    );

    scope_column_pacer scope_column_pacer_inst
    (
        .pix_clk        (pix_clk),
        .rstn           (rstn),
        .i_de           (i_de),
        .o_phase        (phase),
        .o_point_done   (o_point_done)
    );

    // same-cycle pixel decision
    scope_plot_rules scope_plot_rules_inst
    (
        .i_view         (view),
        .i_phase        (phase),
        .i_act_x        (i_act_x),
        .i_act_y        (i_act_y),
        .i_dram_data    (i_dram_data),
        .o_ink          (ink)
    );

    scope_pixel_out scope_pixel_out_inst
    (
        .pix_clk        (pix_clk),
        .rstn           (rstn),
        .i_ink          (ink),
        .i_vs           (i_vs),
        .i_hs           (i_hs),
        .i_de           (i_de),
        .o_vs           (o_vs),
        .o_hs           (o_hs),
        .o_de           (o_de),
        .o_r            (o_r),
        .o_g            (o_g),
        .o_b            (o_b)
    );

endmodule

`default_nettype wire

// File: scope_pixel_out.sv
`timescale 1ns/1ps
`default_nettype none

`include "scope_settings.svh"

module scope_pixel_out
    import scope_pkg::*;
(
    input  wire         pix_clk,
    input  wire         rstn,
    input  ink_t        i_ink,
    input  logic        i_vs,
    input  logic        i_hs,
    input  logic        i_de,
    output logic        o_vs,
    output logic        o_hs,
    output logic        o_de,
    output logic [7:0]  o_r,
    output logic [7:0]  o_g,
    output logic [7:0]  o_b
);

    logic [`SCOPE_COLOR_W-1:0]  color_d;
    logic [`SCOPE_COLOR_W-1:0]  color_q;

    assign color_d = (i_ink == INK_DARK) ? `SCOPE_INK : `SCOPE_PAPER;

    // colour and syncs leave on the same edge
    always_ff @(posedge pix_clk or negedge rstn)
    begin
        if (!rstn)
        begin
            color_q <= `SCOPE_PAPER;
            o_vs    <= 1'b0;
            o_hs    <= 1'b0;
            o_de    <= 1'b0;
        end
        else
        begin
            color_q <= color_d;
            o_vs    <= i_vs;
            o_hs    <= i_hs;
            o_de    <= i_de;
        end
    end

    // packed as r, g, b from msb down
    assign {o_r, o_g, o_b} = color_q;

    a_mono_channels: assert property (@(posedge pix_clk) disable iff (!rstn)
        (o_r inside {8'h00, 8'hFF})
        && (o_g inside {8'h00, 8'hFF})
        && (o_b inside {8'h00, 8'hFF}));

endmodule

`default_nettype wire

// File: scope_pkg.sv
`default_nettype none

package scope_pkg;

    // screen layout chosen by the key
    typedef enum logic [1:0]
    {
        VIEW_TRACE    = 2'd0,
        VIEW_SPECTRUM = 2'd1,
        VIEW_BLANK    = 2'd2
    } view_t;

    // column pacer phase
    // dashes draw in DASH_A/B, bars in BAR_A/B
    typedef enum logic [2:0]
    {
        PACE_GAP    = 3'd0,
        PACE_DASH_A = 3'd1,
        PACE_DASH_B = 3'd2,
        PACE_BAR_A  = 3'd3,
        PACE_BAR_B  = 3'd4
    } pace_t;

    // per-pixel verdict
    typedef enum logic
    {
        INK_PAPER = 1'b0,
        INK_DARK  = 1'b1
    } ink_t;

endpackage

`default_nettype wire

// File: scope_plot_rules.sv
`timescale 1ns/1ps
`default_nettype none

`include "scope_settings.svh"

module scope_plot_rules
    import scope_pkg::*;
(
    input  view_t                       i_view,
    input  pace_t                       i_phase,
    input  logic [`SCOPE_COORD_W-1:0]   i_act_x,
    input  logic [`SCOPE_COORD_W-1:0]   i_act_y,
    input  logic [`SCOPE_SAMPLE_W-1:0]  i_dram_data,
    output ink_t                        o_ink
);

    // one spare bit so row plus sample never wraps
    localparam int SUM_W = `SCOPE_COORD_W + 1;

    logic [7:0]         trace_val;
    logic [8:0]         freq_val;
    logic [SUM_W-1:0]   trace_sum;
    logic [SUM_W-1:0]   freq_sum;

    logic               right_of_labels;
    logic               dash_phase;
    logic               bar_phase;
    logic               on_mid;
    logic               on_bottom;
    logic               on_dash_row;
    logic               in_trace_win;
    logic               in_lower_half;

    logic               upper_bar;
    logic               lower_bar;
    logic               on_trace;
    logic               on_dash;

    // sample word fields
    assign trace_val = i_dram_data[7:0];
    assign freq_val  = i_dram_data[9:1];

    assign trace_sum = SUM_W'(i_act_y) + SUM_W'(trace_val);
    assign freq_sum  = SUM_W'(i_act_y) + SUM_W'(freq_val);

    // pacer duty
    assign dash_phase = (i_phase == PACE_DASH_A) || (i_phase == PACE_DASH_B);
    assign bar_phase  = (i_phase == PACE_BAR_A)  || (i_phase == PACE_BAR_B);

    // row and column limits
    assign right_of_labels = (i_act_x >= `SCOPE_LABEL_COLS);
    assign on_mid          = (i_act_y == `SCOPE_MID_ROW);
    assign on_bottom       = (i_act_y == `SCOPE_BOTTOM_ROW);
    assign on_dash_row     = (i_act_y == `SCOPE_TRACE_TOP)
                          || (i_act_y == `SCOPE_DASH_MID)
                          || (i_act_y == `SCOPE_TRACE_BASE);
    assign in_trace_win    = (i_act_y >= `SCOPE_TRACE_TOP)
                          && (i_act_y <= `SCOPE_TRACE_BASE);
    assign in_lower_half   = (i_act_y > `SCOPE_MID_ROW)
                          && (i_act_y < `SCOPE_BOTTOM_ROW);

    // bars grow up from the midline and from the bottom row
    assign upper_bar = (i_act_y < `SCOPE_MID_ROW) && bar_phase
                    && (freq_sum > SUM_W'(`SCOPE_MID_ROW + 1));
    assign lower_bar = in_lower_half && bar_phase
                    && (freq_sum > SUM_W'(`SCOPE_BOTTOM_ROW));

    // trace is two rows thick, value 0 sits on the base row
    assign on_trace = right_of_labels && in_trace_win
                   && ((trace_sum == SUM_W'(`SCOPE_TRACE_BASE))
                   ||  (trace_sum == SUM_W'(`SCOPE_TRACE_BASE - 1)));

    assign on_dash = on_dash_row && right_of_labels && dash_phase;

    always_comb
    begin
        o_ink = INK_PAPER;
        case (i_view)
            VIEW_TRACE:
            begin
                if (upper_bar)
                    o_ink = INK_DARK;
                else if (on_mid)
                    o_ink = INK_DARK;
                else if (on_trace)
                    o_ink = INK_DARK;
                else if (on_dash)
                    o_ink = INK_DARK;
            end
            VIEW_SPECTRUM:
            begin
                if (upper_bar)
                    o_ink = INK_DARK;
                else if (on_mid)
                    o_ink = INK_DARK;
                else if (lower_bar)
                    o_ink = INK_DARK;
                else if (on_bottom)
                    o_ink = INK_DARK;
            end
            // blank view and unused codes
            default:
            begin
                o_ink = INK_PAPER;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: scope_settings.svh
`ifndef SCOPE_SETTINGS_SVH
`define SCOPE_SETTINGS_SVH

// bus widths
`define SCOPE_COORD_W       13
`define SCOPE_SAMPLE_W      16
`define SCOPE_KEY_W         3
`define SCOPE_COLOR_W       24

// left margin, no trace or dashes to its left
`define SCOPE_LABEL_COLS    48

// spectrum midline and lower base line
`define SCOPE_MID_ROW       359
`define SCOPE_BOTTOM_ROW    719

// trace window, also the upper and lower dashed rows
`define SCOPE_TRACE_TOP     411
`define SCOPE_TRACE_BASE    667

// dashed row between the window edges
`define SCOPE_DASH_MID      539

// pacer wraps after this count
`define SCOPE_PACE_LAST     4

// monochrome palette
`define SCOPE_INK           24'h000000
`define SCOPE_PAPER         24'hFFFFFF

`endif
